// ==== hdl/mipsMacros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_XLEN 32
`define MIPS_NREGS 32

// Primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDI 6'h08
`define OP_ADDIU 6'h09
`define OP_SLTI 6'h0a
`define OP_ANDI 6'h0c
`define OP_ORI 6'h0d
`define OP_XORI 6'h0e
`define OP_LW 6'h23
`define OP_SW 6'h2b

// R-type function codes, instr[5:0]
`define FN_ADD 6'h20
`define FN_ADDU 6'h21
`define FN_SUB 6'h22
`define FN_SUBU 6'h23
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_XOR 6'h26
`define FN_NOR 6'h27
`define FN_SLT 6'h2a

`endif

// ==== hdl/mipsPkg.sv ====
`default_nettype none
`include "mipsMacros.svh"

package mipsPkg;

	typedef logic [`MIPS_XLEN-1:0] wordT;
	typedef logic [$clog2(`MIPS_NREGS)-1:0] regAddrT;

	typedef enum logic [2:0] {
		aluAnd,
		aluOr,
		aluAdd,
		aluSub,
		aluXor,
		aluNor,
		aluSlt
	} aluOpT;

	typedef enum logic [1:0] {
		apbIdle,
		apbSetup,
		apbAccess
	} apbStateT;

	typedef struct packed {
		aluOpT aluOp;
		logic useImm; // B operand from immediate
		logic signExt;
		logic regDst; // Write rd, else rt
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic branchEq;
		logic branchNe;
		logic jump;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		wordT pc4;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		wordT aluResult;
		wordT storeData;
		regAddrT rd;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		wordT result;
		regAddrT rd;
	} memWbT;

endpackage

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsMacros.svh"

module instrDecoder (
	input wire mipsPkg::wordT instr,
	output mipsPkg::ctrlT ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		ctrl = '0;
		case (opcode)
			`OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				case (funct)
					`FN_ADD, `FN_ADDU: ctrl.aluOp = mipsPkg::aluAdd; // No overflow trap
					`FN_SUB, `FN_SUBU: ctrl.aluOp = mipsPkg::aluSub;
					`FN_AND: ctrl.aluOp = mipsPkg::aluAnd;
					`FN_OR: ctrl.aluOp = mipsPkg::aluOr;
					`FN_XOR: ctrl.aluOp = mipsPkg::aluXor;
					`FN_NOR: ctrl.aluOp = mipsPkg::aluNor;
					`FN_SLT: ctrl.aluOp = mipsPkg::aluSlt;
					default: ctrl = '0; // Includes the all-zero word
				endcase
			end
			`OP_ADDI, `OP_ADDIU: begin
				ctrl.aluOp = mipsPkg::aluAdd;
				ctrl.useImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			`OP_SLTI: begin
				ctrl.aluOp = mipsPkg::aluSlt;
				ctrl.useImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			`OP_ANDI, `OP_ORI, `OP_XORI: begin
				ctrl.aluOp = (opcode == `OP_ANDI) ? mipsPkg::aluAnd :
					(opcode == `OP_ORI) ? mipsPkg::aluOr : mipsPkg::aluXor;
				ctrl.useImm = 1'b1; // Logical immediates are zero extended
				ctrl.regWrite = 1'b1;
			end
			`OP_LW, `OP_SW: begin
				ctrl.aluOp = mipsPkg::aluAdd; // Base plus offset
				ctrl.useImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.regWrite = (opcode == `OP_LW);
				ctrl.memRead = (opcode == `OP_LW);
				ctrl.memWrite = (opcode == `OP_SW);
			end
			`OP_BEQ, `OP_BNE: begin
				ctrl.aluOp = mipsPkg::aluSub;
				ctrl.signExt = 1'b1;
				ctrl.branchEq = (opcode == `OP_BEQ);
				ctrl.branchNe = (opcode == `OP_BNE);
			end
			`OP_J: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsMacros.svh"

module regFile (
	input wire logic clk,
	input wire logic rst,
	input wire mipsPkg::regAddrT rs,
	input wire mipsPkg::regAddrT rt,
	output mipsPkg::wordT rsData,
	output mipsPkg::wordT rtData,
	input wire logic wrEn,
	input wire mipsPkg::regAddrT wrAddr,
	input wire mipsPkg::wordT wrData
);

	mipsPkg::wordT regs [`MIPS_NREGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write shows up on the read ports
	assign rsData = (rs == '0) ? '0 : (wrEn && wrAddr == rs) ? wrData : regs[rs];
	assign rtData = (rt == '0) ? '0 : (wrEn && wrAddr == rt) ? wrData : regs[rt];

endmodule

`default_nettype wire

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input wire mipsPkg::regAddrT idRs,
	input wire mipsPkg::regAddrT idRt,
	input wire mipsPkg::idExT ex,
	input wire mipsPkg::exMemT mem,
	input wire mipsPkg::memWbT wb,
	input wire logic branchTaken,
	input wire logic jumpId,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB,
	output logic stall,
	output logic flushIfId,
	output logic flushIdEx
);

	// 0 keeps the ID/EX copy, 1 takes MEM, 2 takes WB
	function automatic logic [1:0] fwdSel(input mipsPkg::regAddrT src);
		if (src == '0)
			return 2'd0;
		if (mem.regWrite && !mem.memRead && mem.rd == src)
			return 2'd1; // Youngest result wins
		if (wb.regWrite && wb.rd == src)
			return 2'd2;
		return 2'd0;
	endfunction

	always_comb begin
		fwdA = fwdSel(ex.rs);
		fwdB = fwdSel(ex.rt);
	end

	assign stall = ex.ctrl.memRead && ex.rd != '0 && (ex.rd == idRs || ex.rd == idRt);

	assign flushIdEx = branchTaken | stall; // Stall leaves a bubble in EX
	assign flushIfId = branchTaken | (jumpId & ~stall);

endmodule

`default_nettype wire

// ==== hdl/aluExec.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsMacros.svh"

module aluExec (
	input wire mipsPkg::idExT ex,
	input wire logic [1:0] fwdA,
	input wire logic [1:0] fwdB,
	input wire mipsPkg::wordT memResult,
	input wire mipsPkg::wordT wbResult,
	output mipsPkg::wordT result,
	output mipsPkg::wordT storeData,
	output logic branchTaken
);

	mipsPkg::wordT opA;
	mipsPkg::wordT rtVal;
	mipsPkg::wordT opB;

	function automatic mipsPkg::wordT pickFwd(input logic [1:0] sel, input mipsPkg::wordT regVal,
			input mipsPkg::wordT memVal, input mipsPkg::wordT wbVal);
		case (sel)
			2'd1: return memVal;
			2'd2: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickFwd(fwdA, ex.rsVal, memResult, wbResult);
	assign rtVal = pickFwd(fwdB, ex.rtVal, memResult, wbResult);
	assign opB = ex.ctrl.useImm ? ex.imm : rtVal;
	assign storeData = rtVal;

	always_comb begin
		case (ex.ctrl.aluOp)
			mipsPkg::aluAnd: result = opA & opB;
			mipsPkg::aluOr: result = opA | opB;
			mipsPkg::aluAdd: result = opA + opB;
			mipsPkg::aluSub: result = opA - opB;
			mipsPkg::aluXor: result = opA ^ opB;
			mipsPkg::aluNor: result = ~(opA | opB);
			mipsPkg::aluSlt: result = {{(`MIPS_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: result = '0;
		endcase
	end

	// Compare uses rt even though B may be the immediate
	assign branchTaken = (ex.ctrl.branchEq && opA == rtVal) || (ex.ctrl.branchNe && opA != rtVal);

endmodule

`default_nettype wire

// ==== hdl/apbDataPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module apbDataPort (
	input wire logic clk,
	input wire logic rst,
	input wire mipsPkg::exMemT mem,
	output mipsPkg::wordT loadData,
	output logic busy,
	output mipsPkg::wordT paddr,
	output logic pwrite,
	output logic psel,
	output logic penable,
	output mipsPkg::wordT pwdata,
	input wire mipsPkg::wordT prdata,
	input wire logic pready
);

	mipsPkg::apbStateT state;
	mipsPkg::apbStateT phase;
	logic memOp;

	assign memOp = mem.memRead | mem.memWrite;

	// First cycle of an access in MEM is the setup phase
	assign phase = (state == mipsPkg::apbIdle && memOp) ? mipsPkg::apbSetup : state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mipsPkg::apbIdle;
		end else begin
			case (phase)
				mipsPkg::apbSetup: state <= mipsPkg::apbAccess;
				mipsPkg::apbAccess: if (pready) state <= mipsPkg::apbIdle;
				default: state <= mipsPkg::apbIdle;
			endcase
		end
	end

	assign psel = (phase != mipsPkg::apbIdle);
	assign penable = (phase == mipsPkg::apbAccess);
	assign busy = psel & ~(penable & pready); // Released in the completion cycle

	// EX/MEM is frozen while busy, so these hold for the whole transfer
	assign paddr = mem.aluResult;
	assign pwrite = mem.memWrite;
	assign pwdata = mem.storeData;
	assign loadData = prdata; // MEM/WB takes it at the completion edge

endmodule

`default_nettype wire

// ==== hdl/mipsPipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline (
	input wire logic clk,
	input wire logic rst,
	output mipsPkg::wordT imemAddr,
	input wire mipsPkg::wordT imemData,
	output mipsPkg::wordT paddr,
	output logic pwrite,
	output logic psel,
	output logic penable,
	output mipsPkg::wordT pwdata,
	input wire mipsPkg::wordT prdata,
	input wire logic pready
);

	mipsPkg::wordT pc;
	mipsPkg::wordT pcPlus4;
	mipsPkg::wordT ifIdInstr;
	mipsPkg::wordT ifIdPc4;
	mipsPkg::wordT jumpTarget;
	mipsPkg::wordT branchTarget;
	mipsPkg::wordT rsData;
	mipsPkg::wordT rtData;
	mipsPkg::wordT immExt;
	mipsPkg::wordT aluResult;
	mipsPkg::wordT storeData;
	mipsPkg::wordT loadData;
	mipsPkg::regAddrT idRs;
	mipsPkg::regAddrT idRt;
	mipsPkg::ctrlT idCtrl;
	mipsPkg::idExT idExNext;
	mipsPkg::idExT idEx;
	mipsPkg::exMemT exMem;
	mipsPkg::memWbT memWb;
	logic [1:0] fwdA;
	logic [1:0] fwdB;
	logic stall;
	logic flushIfId;
	logic flushIdEx;
	logic branchTaken;
	logic busy;

	assign imemAddr = pc;
	assign pcPlus4 = pc + 32'd4;

	assign idRs = ifIdInstr[25:21];
	assign idRt = ifIdInstr[20:16];
	assign immExt = idCtrl.signExt ? {{16{ifIdInstr[15]}}, ifIdInstr[15:0]} :
		{16'b0, ifIdInstr[15:0]};
	assign jumpTarget = {ifIdPc4[31:28], ifIdInstr[25:0], 2'b00};
	assign branchTarget = idEx.pc4 + {idEx.imm[29:0], 2'b00}; // Resolved in EX

	instrDecoder decoder_i (
		.instr(ifIdInstr),
		.ctrl(idCtrl)
	);

	regFile regFile_i (
		.clk(clk),
		.rst(rst),
		.rs(idRs),
		.rt(idRt),
		.rsData(rsData),
		.rtData(rtData),
		.wrEn(memWb.regWrite),
		.wrAddr(memWb.rd),
		.wrData(memWb.result)
	);

	always_comb begin
		idExNext.ctrl = idCtrl;
		idExNext.pc4 = ifIdPc4;
		idExNext.rsVal = rsData;
		idExNext.rtVal = rtData;
		idExNext.imm = immExt;
		idExNext.rs = idRs;
		idExNext.rt = idRt;
		idExNext.rd = idCtrl.regDst ? ifIdInstr[15:11] : idRt;
	end

	hazardUnit hazard_i (
		.idRs(idRs),
		.idRt(idRt),
		.ex(idEx),
		.mem(exMem),
		.wb(memWb),
		.branchTaken(branchTaken),
		.jumpId(idCtrl.jump),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stall(stall),
		.flushIfId(flushIfId),
		.flushIdEx(flushIdEx)
	);

	aluExec alu_i (
		.ex(idEx),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.memResult(exMem.aluResult),
		.wbResult(memWb.result),
		.result(aluResult),
		.storeData(storeData),
		.branchTaken(branchTaken)
	);

	apbDataPort apb_i (
		.clk(clk),
		.rst(rst),
		.mem(exMem),
		.loadData(loadData),
		.busy(busy),
		.paddr(paddr),
		.pwrite(pwrite),
		.psel(psel),
		.penable(penable),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			ifIdInstr <= '0;
			ifIdPc4 <= '0;
			idEx <= '0;
			exMem <= '0;
			memWb <= '0;
		end else if (!busy) begin // Whole pipe freezes during a bus transfer
			if (branchTaken)
				pc <= branchTarget;
			else if (!stall)
				pc <= idCtrl.jump ? jumpTarget : pcPlus4;

			if (flushIfId) begin
				ifIdInstr <= '0; // Decodes as a bubble
			end else if (!stall) begin
				ifIdInstr <= imemData;
				ifIdPc4 <= pcPlus4;
			end

			idEx <= flushIdEx ? '0 : idExNext;

			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memRead <= idEx.ctrl.memRead;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.aluResult <= aluResult;
			exMem.storeData <= storeData;
			exMem.rd <= idEx.rd;

			memWb.regWrite <= exMem.regWrite;
			memWb.result <= exMem.memRead ? loadData : exMem.aluResult;
			memWb.rd <= exMem.rd;
		end
	end

endmodule

`default_nettype wire

// ==== tests/mipsPipeline_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsPipeline_assertions (
	input wire logic clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic pready,
	input wire mipsPkg::wordT paddr,
	input wire mipsPkg::wordT pwdata,
	input wire mipsPkg::wordT pc,
	input wire logic busy
);

	logic waiting;

	assign waiting = psel && penable && !pready; // Access with a wait state

	setupToAccess: assert property (@(posedge clk) disable iff (rst)
		psel && !penable |=> psel && penable && $stable(paddr) && $stable(pwrite) &&
		$stable(pwdata))
		else $error("setup not followed by a steady access cycle");

	waitHolds: assert property (@(posedge clk) disable iff (rst)
		waiting |=> psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else $error("transfer changed during a wait state");

	completionEnds: assert property (@(posedge clk) disable iff (rst)
		psel && penable && pready |=> !penable)
		else $error("access continued after completion");

	// Frozen pipe keeps its fetch address
	freezeHoldsPc: assert property (@(posedge clk) disable iff (rst) busy |=> $stable(pc))
		else $error("PC moved while the data port was busy");

endmodule

`default_nettype wire

// ==== tests/mipsPipelineTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mipsMacros.svh"

module mipsPipelineTb;

	localparam int PROG_LEN = 64;
	localparam int MAX_CYCLES = PROG_LEN * (3 + 5) + 100;
	localparam mipsPkg::wordT LOOP_ADDR = (PROG_LEN - 1) * 4; // Final self-loop J
	localparam logic [5:0] FUNCTS [9] = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND,
		`FN_OR, `FN_XOR, `FN_NOR, `FN_SLT};
	localparam logic [5:0] IMM_OPS [6] = '{`OP_ADDI, `OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI,
		`OP_SLTI};

	logic clk;
	logic rst;
	mipsPkg::wordT imemAddr;
	mipsPkg::wordT imemData;
	mipsPkg::wordT paddr;
	logic pwrite;
	logic psel;
	logic penable;
	mipsPkg::wordT pwdata;
	mipsPkg::wordT prdata;
	logic pready;

	logic [31:0] lfsr;
	mipsPkg::wordT prog [PROG_LEN];
	mipsPkg::wordT slaveMem [64];
	mipsPkg::wordT modelMem [64];
	mipsPkg::wordT modelRegs [32];
	mipsPkg::wordT expAddr [$];
	mipsPkg::wordT expData [$];
	mipsPkg::wordT heldAddr;
	mipsPkg::wordT heldData;
	logic heldWrite;
	logic prevDone;
	int storesSeen;
	int cycles;
	int waitLeft;

	bind mipsPipeline mipsPipeline_assertions apbChecks_i (.*);

	mipsPipeline dut_i (
		.clk(clk),
		.rst(rst),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.paddr(paddr),
		.pwrite(pwrite),
		.psel(psel),
		.penable(penable),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready)
	);

	assign imemData = prog[imemAddr[7:2]]; // Combinational fetch port

	always #20 clk = ~clk;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
		end
		return val;
	endfunction

	function automatic logic [4:0] pickReg();
		logic [4:0] r;
		r = 5'(randBits(3));
		return (r == 5'd0) ? 5'd7 : r; // Registers 1 to 7 only
	endfunction

	function automatic mipsPkg::wordT fillWord(input int i);
		return (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
	endfunction

	task automatic plainFail(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic valueFail(input string name, input mipsPkg::wordT got,
			input mipsPkg::wordT exp);
		plainFail($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	task automatic genProgram();
		logic [3:0] kind;
		logic [3:0] fnSel;
		logic [2:0] opSel;
		int off;
		int target;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			kind = 4'(randBits(4));
			if (kind < 4'd5) begin
				fnSel = 4'(randBits(4) % 9);
				prog[i] = {`OP_RTYPE, pickReg(), pickReg(), pickReg(), 5'd0, FUNCTS[fnSel]};
			end else if (kind < 4'd9) begin
				opSel = 3'(randBits(3) % 6);
				prog[i] = {IMM_OPS[opSel], pickReg(), pickReg(), 16'(randBits(16))};
			end else if (kind < 4'd14) begin
				// Base is r0, so the offset alone picks the word
				prog[i] = {(kind < 4'd11) ? `OP_LW : `OP_SW, 5'd0, pickReg(), 8'd0,
					6'(randBits(6)), 2'b00};
			end else if (kind == 4'd14) begin
				off = int'(randBits(2));
				if (i + 1 + off > PROG_LEN - 1)
					off = PROG_LEN - 2 - i;
				prog[i] = {randBits(1) ? `OP_BNE : `OP_BEQ, pickReg(), pickReg(), 16'(off)};
			end else begin
				target = i + 1 + int'(randBits(2));
				if (target > PROG_LEN - 1)
					target = PROG_LEN - 1;
				prog[i] = {`OP_J, 26'(target)};
			end
		end
		prog[PROG_LEN - 1] = {`OP_J, 26'(PROG_LEN - 1)};
	endtask

	// Sequential ISA model, no delay slots
	task automatic runModel();
		int idx;
		mipsPkg::wordT ins;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wordT sImm;
		mipsPkg::wordT addr;
		mipsPkg::wordT res;
		logic [4:0] dest;
		logic wr;
		for (int r = 0; r < 32; r++) begin
			modelRegs[r] = '0;
		end
		idx = 0;
		while (idx != PROG_LEN - 1) begin
			ins = prog[idx];
			a = modelRegs[ins[25:21]];
			b = modelRegs[ins[20:16]];
			sImm = {{16{ins[15]}}, ins[15:0]};
			addr = a + sImm;
			dest = ins[20:16];
			wr = 1'b1;
			res = '0;
			idx++;
			case (ins[31:26])
				`OP_RTYPE: begin
					dest = ins[15:11];
					case (ins[5:0])
						`FN_ADD, `FN_ADDU: res = a + b;
						`FN_SUB, `FN_SUBU: res = a - b;
						`FN_AND: res = a & b;
						`FN_OR: res = a | b;
						`FN_XOR: res = a ^ b;
						`FN_NOR: res = ~(a | b);
						default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
				end
				`OP_ADDI, `OP_ADDIU: res = addr;
				`OP_SLTI: res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
				`OP_ANDI: res = a & {16'h0, ins[15:0]};
				`OP_ORI: res = a | {16'h0, ins[15:0]};
				`OP_XORI: res = a ^ {16'h0, ins[15:0]};
				`OP_LW: res = modelMem[addr[7:2]];
				`OP_SW: begin
					wr = 1'b0;
					modelMem[addr[7:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				`OP_BEQ, `OP_BNE: begin
					wr = 1'b0;
					if ((a == b) == (ins[31:26] == `OP_BEQ))
						idx = idx + int'(ins[15:0]);
				end
				default: begin
					wr = 1'b0;
					idx = int'(ins[25:0]); // J
				end
			endcase
			if (wr && dest != 5'd0)
				modelRegs[dest] = res;
		end
	endtask

	// APB slave with random wait states, plus bus monitor
	always @(negedge clk) begin
		pready = 1'b0;
		assert (!(prevDone && penable)) else plainFail("transfer ran on past its completion cycle");
		if (psel && !penable) begin
			waitLeft = int'(randBits(2));
			heldAddr = paddr;
			heldWrite = pwrite;
			heldData = pwdata;
			assert (paddr[31:8] == 24'd0 && paddr[1:0] == 2'd0)
				else plainFail("bus address outside the data window");
		end else if (psel && penable) begin
			assert (paddr == heldAddr) else valueFail("paddr", paddr, heldAddr);
			assert (pwrite == heldWrite) else valueFail("pwrite", 32'(pwrite), 32'(heldWrite));
			assert (pwdata == heldData) else valueFail("pwdata", pwdata, heldData);
			if (waitLeft == 0) begin
				pready = 1'b1;
				if (pwrite) begin
					assert (storesSeen < expAddr.size())
						else plainFail("store on the bus that the model never executes");
					assert (paddr == expAddr[storesSeen])
						else valueFail("paddr", paddr, expAddr[storesSeen]);
					assert (pwdata == expData[storesSeen])
						else valueFail("pwdata", pwdata, expData[storesSeen]);
					slaveMem[paddr[7:2]] = pwdata;
					storesSeen++;
				end else begin
					prdata = slaveMem[paddr[7:2]];
				end
			end else begin
				waitLeft--;
			end
		end
		prevDone = psel && penable && pready;
	end

	always @(posedge clk) begin
		if (!rst) begin
			cycles++;
			assert (cycles < MAX_CYCLES) else plainFail("timeout before the program reached its end");
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		pready = 1'b0;
		prdata = '0;
		lfsr = 32'he764_3b34;
		storesSeen = 0;
		cycles = 0;
		waitLeft = 0;
		prevDone = 1'b0;
		genProgram();
		for (int i = 0; i < 64; i++) begin
			slaveMem[i] = fillWord(i);
			modelMem[i] = fillWord(i);
		end
		runModel();
		repeat (8) @(negedge clk);
		assert (!psel && !penable && !pwrite) else plainFail("APB outputs not idle after reset");
		assert (imemAddr == '0) else valueFail("imemAddr", imemAddr, '0);
		rst = 1'b0;
		while (!(storesSeen == expAddr.size() && imemAddr == LOOP_ADDR)) begin
			@(negedge clk);
		end
		repeat (12) @(negedge clk); // Drain, so a stray store would still show up
		for (int i = 0; i < 64; i++) begin
			assert (slaveMem[i] == modelMem[i])
				else valueFail($sformatf("slaveMem[%0d]", i), slaveMem[i], modelMem[i]);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/mipsPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/aluExec.sv
hdl/apbDataPort.sv
hdl/mipsPipeline.sv
tests/mipsPipeline_assertions.sv
tests/mipsPipelineTb.sv

// ==== Makefile ====
SIM ?= verilator
FLAGS ?= --binary --assert --timing
TOP ?= mipsPipelineTb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
